// ==== files.f ====
+incdir+.
uopPkg.sv
uopFetchStage.sv
uopDecoder.sv
uopIssueSteer.sv
uopFrontEnd.sv
tbClockGen.sv
tbUopChecker.sv
tbUopFrontEnd.sv

// ==== tbUopFrontEnd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uop_settings.svh"

module tbUopFrontEnd
	import uopPkg::*;
();

	logic                  clk;
	logic                  rstN;
	logic                  flush;
	logic                  instrValid;
	logic [`UOP_WIDTH-1:0] instr;
	logic                  predictTaken;
	logic                  wbValid;
	logic [`REG_IDX_W-1:0] wbReg;
	logic                  issueAlu, issueMem, issueFcu;
	logic                  outLoad, outStore, outCmp, outBranch, outJmp;
	logic                  outSei, outRfw, outNeedSr, outWrap;
	memSize_t              outMemSize;
	logic [`REG_IDX_W:0]   outSrc1;
	logic [`REG_IDX_W-1:0] outSrc2;
	logic [`REG_IDX_W-1:0] outDst;
	logic                  outPredict;
	logic                  hazard;
	int                    checkCount;
	int                    errorCount;
	logic                  idle;
	logic [15:0]           lfsr;
	int                    testErrors;

	tbClockGen uClock (.*);

	uopFrontEnd i_uopFrontEnd (.*);

	tbUopChecker uChecker (.*);

	// ========================================
	// random source and helpers
	// ========================================

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one step per bit taken
	task automatic takeBits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[14:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic sendUop(input logic [`UOP_WIDTH-1:0] w, input logic p);
		instrValid   = 1'b1;
		instr        = w;
		predictTaken = p;
		nextCycle();
		instrValid = 1'b0;
	endtask

	task automatic waitReset();
		int waited;
		waited = 0;
		while (rstN !== 1'b1)
		begin
			if (waited == 10)
			begin
				$display("timeout: reset was never released");
				$display("** FAIL **");
				$finish;
			end
			@(posedge clk);
			waited++;
		end
		#1;
	endtask

	task automatic drainPipe();
		int waited;
		waited = 0;
		while (!idle)
		begin
			if (waited == 20)
			begin
				$display("timeout: micro-ops still in flight after %0d cycles", waited);
				$display("** FAIL **");
				$finish;
			end
			nextCycle();
			waited++;
		end
	endtask

	task automatic finishTest(input string name);
		drainPipe();
		$display("test %-14s %s (%0d errors)", name,
			(errorCount == testErrors) ? "ok" : "failed", errorCount - testErrors);
		testErrors = errorCount;
	endtask

	task automatic clearScoreboard();
		for (int r = 0; r < `REG_COUNT; r++)
		begin
			wbValid = 1'b1;
			wbReg   = r[`REG_IDX_W-1:0];
			nextCycle();
		end
		wbValid = 1'b0;
	endtask

	// ========================================
	// stimulus
	// ========================================

	initial
	begin : stimulus
		logic [15:0] rnd;
		logic [15:0] word;
		logic [15:0] pred;
		flush        = 1'b0;
		instrValid   = 1'b0;
		instr        = '0;
		predictTaken = 1'b0;
		wbValid      = 1'b0;
		wbReg        = '0;
		lfsr         = 16'd46;
		testErrors   = 0;

		// pulses and hazard low during and just after reset
		waitReset();
		finishTest("reset");

		// every opcode once, random register fields
		for (int op = 0; op < 64; op++)
		begin
			takeBits(10, rnd);
			takeBits(1, pred);
			sendUop({op[5:0], rnd[9:0]}, pred[0]);
		end
		finishTest("opcode sweep");

		// random stream with gaps and writebacks
		for (int n = 0; n < 200; n++)
		begin
			takeBits(2, rnd);
			// roughly one slot in four left empty
			if (rnd[1:0] == 2'd0)
				nextCycle();
			takeBits(4, rnd);
			wbValid = rnd[3];
			wbReg   = rnd[2:0];
			takeBits(16, word);
			takeBits(1, pred);
			sendUop(word, pred[0]);
		end
		wbValid = 1'b0;
		finishTest("random stream");

		// writer then reader of r3, then the same reader after writeback
		clearScoreboard();
		sendUop({ADDB, 4'b1000, 3'd3, 3'd0}, 1'b0);
		sendUop({ANDB, 4'b1000, 3'd5, 3'd3}, 1'b0);
		drainPipe();
		wbValid = 1'b1;
		wbReg   = 3'd3;
		nextCycle();
		wbValid = 1'b0;
		sendUop({ANDB, 4'b1000, 3'd5, 3'd3}, 1'b0);
		// src1 with bit 3 set names no register
		sendUop({ADDB, 4'b1000, 3'd3, 3'd0}, 1'b0);
		sendUop({CMPB, 4'b1011, 3'd0, 3'd6}, 1'b0);
		finishTest("scoreboard");

		// flush with three in flight, then with two
		sendUop({LDB, 4'b0001, 3'd2, 3'd4}, 1'b1);
		sendUop({ADDW, 4'b1000, 3'd1, 3'd2}, 1'b0);
		flush = 1'b1;
		sendUop({JMP, 4'b1000, 3'd0, 3'd0}, 1'b1);
		flush = 1'b0;
		sendUop({STW, 4'b0010, 3'd6, 3'd1}, 1'b0);
		sendUop({BEQ, 4'b1000, 3'd0, 3'd0}, 1'b1);
		flush = 1'b1;
		nextCycle();
		flush = 1'b0;
		finishTest("flush");

		// byte stores of every register, only r7 needs the status register
		for (int d = 0; d < 8; d++)
			sendUop({STB, 4'b1000, d[2:0], 3'd0}, 1'b0);
		finishTest("status reg");

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("** PASS **");
		end
		else
		begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tbUopChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uop_settings.svh"

module tbUopChecker
	import uopPkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rstN,
	input  wire logic                  flush,
	input  wire logic                  instrValid,
	input  wire logic [`UOP_WIDTH-1:0] instr,
	input  wire logic                  predictTaken,
	input  wire logic                  wbValid,
	input  wire logic [`REG_IDX_W-1:0] wbReg,
	input  wire logic                  issueAlu, issueMem, issueFcu,
	input  wire logic                  outLoad, outStore, outCmp, outBranch, outJmp,
	input  wire logic                  outSei, outRfw, outNeedSr, outWrap,
	input  wire memSize_t              outMemSize,
	input  wire logic [`REG_IDX_W:0]   outSrc1,
	input  wire logic [`REG_IDX_W-1:0] outSrc2,
	input  wire logic [`REG_IDX_W-1:0] outDst,
	input  wire logic                  outPredict,
	input  wire logic                  hazard,
	output int                         checkCount,
	output int                         errorCount,
	// high when nothing is in flight in the model
	output logic                       idle
);

	// decode slot feeds the hazard check, last slot is the issue register
	localparam int DEC = `PIPE_DEPTH - 2;
	localparam int OUT = `PIPE_DEPTH - 1;

	logic [`PIPE_DEPTH-1:0] slotValid = '0;
	logic [`UOP_WIDTH-1:0]  slotInstr [`PIPE_DEPTH];
	logic [`PIPE_DEPTH-1:0] slotPredict;
	logic [`REG_COUNT-1:0]  busyModel;
	logic                   expHazard;
	logic                   started = 1'b0;

	assign idle = ~|slotValid;

	initial
	begin
		checkCount = 0;
		errorCount = 0;
	end

	// ========================================
	// reference decode
	// ========================================

	// {memSize[2:0], alu, mem, fcu, load, store, cmp, branch, jmp, sei, rfw, needSr, wrap}
	function automatic logic [14:0] refDecode(input logic [`UOP_WIDTH-1:0] w);
		int         op;
		logic       needSr;
		logic [2:0] size;
		op = w[15:10];
		// wyde for LDW, STW, LDWW and STWW
		size = (op inside {23, 25, 27, 29}) ? 3'd1 : 3'd0;
		// carry users, branches, and byte stores of register 7
		needSr = (op inside {3, 4, 12, 13, [30:37]}) || (op inside {24, 28} && w[5:3] == 3'd7);
		return {size,
			1'(op inside {0, [2:16], [19:21]}),
			1'(op inside {[22:29]}),
			1'(op inside {[30:39]}),
			1'(op inside {22, 23, 26, 27}),
			1'(op inside {24, 25, 28, 29}),
			1'(op == 5),
			1'(op inside {[30:37]}),
			1'(op == 39),
			1'(op == 19),
			1'(op inside {[1:4], 6, [8:14], 22, 23, 26, 27}),
			needSr,
			1'(op inside {[26:29]})};
	endfunction

	function automatic string flagName(input int i);
		case (i)
			0: return "outWrap";
			1: return "outNeedSr";
			2: return "outRfw";
			3: return "outSei";
			4: return "outJmp";
			5: return "outBranch";
			6: return "outCmp";
			7: return "outStore";
			8: return "outLoad";
			9: return "issueFcu";
			10: return "issueMem";
			default: return "issueAlu";
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [15:0] expV,
		input logic [15:0] actV);
		checkCount++;
		if (actV !== expV)
		begin
			errorCount++;
			$display("Error %s expected %h got %h at %0t", name, expV, actV, $time);
		end
	endtask

	// ========================================
	// pipeline and scoreboard model
	// ========================================

	always @(posedge clk)
	begin : modelStep
		logic [`UOP_WIDTH-1:0] w;
		logic [14:0]           dec;
		if (!rstN)
		begin
			slotValid = '0;
			busyModel = '0;
			expHazard = 1'b0;
		end
		else
		begin
			w   = slotInstr[DEC];
			dec = refDecode(w);
			// writeback frees its register before the check
			if (wbValid)
				busyModel[wbReg] = 1'b0;
			// src1 counts only with bit 3 clear, stores read dst as data
			expHazard = slotValid[DEC] && ((!w[9] && busyModel[w[8:6]]) || busyModel[w[2:0]]
				|| (dec[7] && busyModel[w[5:3]]));
			if (slotValid[DEC] && dec[2])
				busyModel[w[5:3]] = 1'b1;
			// shift one stage, flush kills what sits ahead of the decode register
			for (int i = OUT; i > 0; i--)
			begin
				slotValid[i]   = slotValid[i-1] & ((i == OUT) ? 1'b1 : ~flush);
				slotInstr[i]   = slotInstr[i-1];
				slotPredict[i] = slotPredict[i-1];
			end
			slotValid[0]   = instrValid & ~flush;
			slotInstr[0]   = instr;
			slotPredict[0] = predictTaken;
		end
		started = 1'b1;
	end

	// ========================================
	// compare on the falling edge
	// ========================================

	always @(negedge clk)
	begin : compareStep
		logic [`UOP_WIDTH-1:0] w;
		logic [14:0]           expVec;
		logic [14:0]           actVec;
		if (started)
		begin
			w      = slotInstr[OUT];
			expVec = slotValid[OUT] ? refDecode(w) : '0;
			actVec = {outMemSize, issueAlu, issueMem, issueFcu, outLoad, outStore, outCmp,
				outBranch, outJmp, outSei, outRfw, outNeedSr, outWrap};
			for (int i = 0; i < 12; i++)
				compareValue(flagName(i), expVec[i], actVec[i]);
			compareValue("hazard", expHazard, hazard);
			// fields only mean something beside a valid micro-op
			if (slotValid[OUT])
			begin
				compareValue("outMemSize", expVec[14:12], actVec[14:12]);
				compareValue("outSrc1", w[9:6], outSrc1);
				compareValue("outDst", w[5:3], outDst);
				compareValue("outSrc2", w[2:0], outSrc2);
				compareValue("outPredict", slotPredict[OUT], outPredict);
			end
		end
	end

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClockGen
(
	output logic clk,
	output logic rstN
);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held over two rising edges, released just after the second
	initial
	begin
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		#1 rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== uopFrontEnd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uop_settings.svh"

module uopFrontEnd
	import uopPkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rstN,
	input  wire logic                  flush,
	input  wire logic                  instrValid,
	input  wire logic [`UOP_WIDTH-1:0] instr,
	input  wire logic                  predictTaken,
	input  wire logic                  wbValid,
	input  wire logic [`REG_IDX_W-1:0] wbReg,
	output logic                       issueAlu,
	output logic                       issueMem,
	output logic                       issueFcu,
	output logic                       outLoad,
	output logic                       outStore,
	output memSize_t                   outMemSize,
	output logic                       outCmp,
	output logic                       outBranch,
	output logic                       outJmp,
	output logic                       outSei,
	output logic                       outRfw,
	output logic                       outNeedSr,
	output logic                       outWrap,
	output logic [`REG_IDX_W:0]        outSrc1,
	output logic [`REG_IDX_W-1:0]      outSrc2,
	output logic [`REG_IDX_W-1:0]      outDst,
	output logic                       outPredict,
	output logic                       hazard
);

	// ========================================
	// stage boundaries
	// ========================================

	// fetch to decode
	logic                  fetchValid;
	logic [`UOP_WIDTH-1:0] fetchInstr;
	logic                  fetchPredict;

	// decode to steering
	logic                  decValid;
	logic                  decAlu, decMem, decFcu;
	logic                  decLoad, decStore, decCmp, decBranch, decJmp;
	logic                  decSei, decRfw, decNeedSr, decWrap;
	memSize_t              decMemSize;
	logic [`REG_IDX_W:0]   decSrc1;
	logic [`REG_IDX_W-1:0] decDst;
	logic [`REG_IDX_W-1:0] decSrc2;
	logic                  decPredict;

	// three registered stages, one micro-op in each
	uopFetchStage uFetch (.*);

	uopDecoder uDecode (.*);

	uopIssueSteer uSteer (.*);

endmodule

`default_nettype wire

// ==== uopIssueSteer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uop_settings.svh"

module uopIssueSteer
	import uopPkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rstN,
	input  wire logic                  decValid,
	input  wire logic                  decAlu,
	input  wire logic                  decMem,
	input  wire logic                  decFcu,
	input  wire logic                  decLoad,
	input  wire logic                  decStore,
	input  wire logic                  decCmp,
	input  wire logic                  decBranch,
	input  wire logic                  decJmp,
	input  wire logic                  decSei,
	input  wire logic                  decRfw,
	input  wire logic                  decNeedSr,
	input  wire logic                  decWrap,
	input  wire memSize_t              decMemSize,
	input  wire logic [`REG_IDX_W:0]   decSrc1,
	input  wire logic [`REG_IDX_W-1:0] decDst,
	input  wire logic [`REG_IDX_W-1:0] decSrc2,
	input  wire logic                  decPredict,
	// writeback frees a register
	input  wire logic                  wbValid,
	input  wire logic [`REG_IDX_W-1:0] wbReg,
	// one cycle issue pulses per unit
	output logic                       issueAlu,
	output logic                       issueMem,
	output logic                       issueFcu,
	output logic                       outLoad,
	output logic                       outStore,
	output memSize_t                   outMemSize,
	output logic                       outCmp,
	output logic                       outBranch,
	output logic                       outJmp,
	output logic                       outSei,
	output logic                       outRfw,
	output logic                       outNeedSr,
	output logic                       outWrap,
	output logic [`REG_IDX_W:0]        outSrc1,
	output logic [`REG_IDX_W-1:0]      outSrc2,
	output logic [`REG_IDX_W-1:0]      outDst,
	output logic                       outPredict,
	output logic                       hazard
);

	// ========================================
	// scoreboard
	// ========================================

	// one busy bit per register, set while a write is outstanding
	logic [`REG_COUNT-1:0] busy;
	logic [`REG_COUNT-1:0] wbClear;
	logic [`REG_COUNT-1:0] busyAfterWb;
	logic [`REG_COUNT-1:0] rfwSet;
	logic                  src1Busy;
	logic                  src2Busy;
	logic                  dstBusy;

	always_comb
	begin
		// writeback clears first, same cycle
		wbClear = '0;
		if (wbValid)
			wbClear[wbReg] = 1'b1;
		busyAfterWb = busy & ~wbClear;
		// src1 bit 3 set means no register operand
		src1Busy = ~decSrc1[`REG_IDX_W] & busyAfterWb[decSrc1[`REG_IDX_W-1:0]];
		src2Busy = busyAfterWb[decSrc2];
		// store data comes from the dst field
		dstBusy  = decStore & busyAfterWb[decDst];
		// destination is marked last, after the check
		rfwSet = '0;
		if (decValid & decRfw)
			rfwSet[decDst] = 1'b1;
	end

	// ========================================
	// steering register
	// ========================================

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy      <= '0;
			hazard    <= 1'b0;
			issueAlu  <= 1'b0;
			issueMem  <= 1'b0;
			issueFcu  <= 1'b0;
			outLoad   <= 1'b0;
			outStore  <= 1'b0;
			outCmp    <= 1'b0;
			outBranch <= 1'b0;
			outJmp    <= 1'b0;
			outSei    <= 1'b0;
			outRfw    <= 1'b0;
			outNeedSr <= 1'b0;
			outWrap   <= 1'b0;
		end
		else
		begin
			busy      <= busyAfterWb | rfwSet;
			// reported only, nothing stalls on it
			hazard    <= decValid & (src1Busy | src2Busy | dstBusy);
			issueAlu  <= decValid & decAlu;
			issueMem  <= decValid & decMem;
			issueFcu  <= decValid & decFcu;
			outLoad   <= decLoad;
			outStore  <= decStore;
			outCmp    <= decCmp;
			outBranch <= decBranch;
			outJmp    <= decJmp;
			outSei    <= decSei;
			outRfw    <= decRfw;
			outNeedSr <= decNeedSr;
			outWrap   <= decWrap;
		end
	end

	// operand fields travel beside the pulses
	always_ff @(posedge clk)
	begin
		outMemSize <= decMemSize;
		outSrc1    <= decSrc1;
		outSrc2    <= decSrc2;
		outDst     <= decDst;
		outPredict <= decPredict;
	end

endmodule

`default_nettype wire

// ==== uopDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uop_settings.svh"

module uopDecoder
	import uopPkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rstN,
	input  wire logic                  flush,
	input  wire logic                  fetchValid,
	input  wire logic [`UOP_WIDTH-1:0] fetchInstr,
	input  wire logic                  fetchPredict,
	output logic                       decValid,
	// class flags
	output logic                       decAlu,
	output logic                       decMem,
	output logic                       decFcu,
	// control flags
	output logic                       decLoad,
	output logic                       decStore,
	output logic                       decCmp,
	output logic                       decBranch,
	output logic                       decJmp,
	output logic                       decSei,
	output logic                       decRfw,
	output logic                       decNeedSr,
	output logic                       decWrap,
	// payload
	output memSize_t                   decMemSize,
	output logic [`REG_IDX_W:0]        decSrc1,
	output logic [`REG_IDX_W-1:0]      decDst,
	output logic [`REG_IDX_W-1:0]      decSrc2,
	output logic                       decPredict
);

	logic [`UOP_OPC_WIDTH-1:0] opc;
	logic [`REG_IDX_W-1:0]     dstField;
	logic                      accept;

	assign opc      = fetchInstr[`UOP_WIDTH-1:`UOP_OPC_LSB];
	assign dstField = fetchInstr[2*`REG_IDX_W-1:`REG_IDX_W];
	// flush kills the micro-op leaving fetch
	assign accept   = fetchValid & ~flush;

	// ========================================
	// opcode classification
	// ========================================

	function automatic logic isAlu(input logic [`UOP_OPC_WIDTH-1:0] op);
		// ADDB goes elsewhere, it is not an ALU op here
		case (op)
			LDIB, ADDW, ADCB, SBCB, CMPB, ANDB, BITB, ORB, EORB,
			ASLB, LSRB, RORB, ROLB, SEC, CLC, SEI, CLI, CLV, MOV:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic isLoad(input logic [`UOP_OPC_WIDTH-1:0] op);
		return op inside {LDB, LDW, LDBW, LDWW};
	endfunction

	function automatic logic isStore(input logic [`UOP_OPC_WIDTH-1:0] op);
		return op inside {STB, STW, STBW, STWW};
	endfunction

	// the eight conditional branches only
	function automatic logic isBranch(input logic [`UOP_OPC_WIDTH-1:0] op);
		return op inside {BEQ, BNE, BCS, BCC, BVS, BVC, BMI, BPL};
	endfunction

	function automatic logic isRfw(input logic [`UOP_OPC_WIDTH-1:0] op);
		case (op)
			LDB, LDW, LDBW, LDWW, ADDB, ADDW, ADCB, SBCB,
			ANDB, ORB, EORB, ASLB, LSRB, ROLB, RORB, MOV:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic memSize_t memSize(input logic [`UOP_OPC_WIDTH-1:0] op);
		// wyde accesses, anything else defaults to byte
		if (op inside {LDW, LDWW, STW, STWW})
			return SZ_WYDE;
		return SZ_BYTE;
	endfunction

	function automatic logic needsSr(
		input logic [`UOP_OPC_WIDTH-1:0] op,
		input logic [`REG_IDX_W-1:0]     dst
	);
		case (op)
			// a store of the status register reads it
			STB, STBW:
				return dst == SR_REG;
			// carry in
			ADCB, SBCB, ROLB, RORB:
				return 1'b1;
			BEQ, BNE, BCS, BCC, BVS, BVC, BMI, BPL:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// ========================================
	// decode register
	// ========================================

	// flags are all gated by the valid bit
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			decValid  <= 1'b0;
			decAlu    <= 1'b0;
			decMem    <= 1'b0;
			decFcu    <= 1'b0;
			decLoad   <= 1'b0;
			decStore  <= 1'b0;
			decCmp    <= 1'b0;
			decBranch <= 1'b0;
			decJmp    <= 1'b0;
			decSei    <= 1'b0;
			decRfw    <= 1'b0;
			decNeedSr <= 1'b0;
			decWrap   <= 1'b0;
		end
		else
		begin
			decValid  <= accept;
			decAlu    <= accept & isAlu(opc);
			decMem    <= accept & (isLoad(opc) | isStore(opc));
			decFcu    <= accept & (isBranch(opc) | opc inside {JSI, JMP});
			decLoad   <= accept & isLoad(opc);
			decStore  <= accept & isStore(opc);
			decCmp    <= accept & (opc == CMPB);
			decBranch <= accept & isBranch(opc);
			decJmp    <= accept & (opc == JMP);
			decSei    <= accept & (opc == SEI);
			decRfw    <= accept & isRfw(opc);
			decNeedSr <= accept & needsSr(opc, dstField);
			// W suffix memory ops wrap within the page
			decWrap   <= accept & (opc inside {LDBW, STBW, LDWW, STWW});
		end
	end

	// register fields, captured with each fetched micro-op
	always_ff @(posedge clk)
	begin
		if (fetchValid)
		begin
			decMemSize <= memSize(opc);
			decSrc1    <= fetchInstr[`UOP_OPC_LSB-1:2*`REG_IDX_W];
			decDst     <= dstField;
			decSrc2    <= fetchInstr[`REG_IDX_W-1:0];
			decPredict <= fetchPredict;
		end
	end

endmodule

`default_nettype wire

// ==== uopFetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uop_settings.svh"

module uopFetchStage
(
	input  wire logic                  clk,
	input  wire logic                  rstN,
	// branch redirect, empties this stage
	input  wire logic                  flush,
	input  wire logic                  instrValid,
	input  wire logic [`UOP_WIDTH-1:0] instr,
	input  wire logic                  predictTaken,
	output logic                       fetchValid,
	output logic [`UOP_WIDTH-1:0]      fetchInstr,
	output logic                       fetchPredict
);

	// ========================================
	// valid bit
	// ========================================

	// one cycle strobe, follows instrValid
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			fetchValid <= 1'b0;
		end
		else
		begin
			// a micro-op arriving with flush is dropped
			fetchValid <= instrValid & ~flush;
		end
	end

	// ========================================
	// micro-op latch
	// ========================================

	// payload only moves on a new micro-op
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			fetchInstr   <= instr;
			fetchPredict <= predictTaken;
		end
	end

endmodule

`default_nettype wire

// ==== uopPkg.sv ====
`default_nettype none

`include "uop_settings.svh"

package uopPkg;

	// ========================================
	// micro-op opcodes
	// ========================================

	// codes 40 to 63 are unused and decode to no class
	typedef enum logic [`UOP_OPC_WIDTH-1:0] {
		LDIB = 6'd0,
		ADDB = 6'd1,
		ADDW = 6'd2,
		ADCB = 6'd3,
		SBCB = 6'd4,
		CMPB = 6'd5,
		ANDB = 6'd6,
		BITB = 6'd7,
		ORB  = 6'd8,
		EORB = 6'd9,
		// shifts and rotates
		ASLB = 6'd10,
		LSRB = 6'd11,
		RORB = 6'd12,
		ROLB = 6'd13,
		MOV  = 6'd14,
		// status flag set and clear
		SEC  = 6'd15,
		CLC  = 6'd16,
		SEI  = 6'd19,
		CLI  = 6'd20,
		CLV  = 6'd21,
		// plain loads and stores
		LDB  = 6'd22,
		LDW  = 6'd23,
		STB  = 6'd24,
		STW  = 6'd25,
		// wrapping loads and stores
		LDBW = 6'd26,
		LDWW = 6'd27,
		STBW = 6'd28,
		STWW = 6'd29,
		// conditional branches
		BEQ  = 6'd30,
		BNE  = 6'd31,
		BCS  = 6'd32,
		BCC  = 6'd33,
		BVS  = 6'd34,
		BVC  = 6'd35,
		BMI  = 6'd36,
		BPL  = 6'd37,
		// unconditional flow control
		JSI  = 6'd38,
		JMP  = 6'd39
	} uopOpcode_t;

	// ========================================
	// memory access size
	// ========================================

	// 3 bits wide, room for larger sizes later
	typedef enum logic [2:0] {
		SZ_BYTE = 3'd0,
		SZ_WYDE = 3'd1
	} memSize_t;

	// register field value naming the status register in a store
	localparam logic [`REG_IDX_W-1:0] SR_REG = 7;

endpackage

`default_nettype wire

// ==== uop_settings.svh ====
`ifndef UOP_SETTINGS_SVH
`define UOP_SETTINGS_SVH

// ========================================
// micro-op word layout
// ========================================

// micro-op word size in bits
`define UOP_WIDTH 16
// opcode sits in the top bits, 15 down to 10
`define UOP_OPC_LSB 10
`define UOP_OPC_WIDTH (`UOP_WIDTH - `UOP_OPC_LSB)

// ========================================
// register file and pipeline
// ========================================

// architectural registers tracked by the scoreboard
`define REG_COUNT 8
// register index width, dst and src2 fields use this many bits
`define REG_IDX_W $clog2(`REG_COUNT)
// input to issue latency in cycles
`define PIPE_DEPTH 3

`endif
